//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int memAddrW = 8;

	typedef logic [15:0] wordT;
	typedef logic [3:0] regIdxT;

	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		MOV  = 4'h6,
		LDI  = 4'h7,
		LD   = 4'h8,
		ST   = 4'h9,
		JMP  = 4'hA,
		JZ   = 4'hB,
		JC   = 4'hC,
		JR   = 4'hD,
		SHL  = 4'hE,
		HALT = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {IDLE, FETCH, EXEC, WBACK, HALTED} cpuStateT;

	typedef enum logic [1:0] {PC_INCR, PC_IMM, PC_REG} pcSelT;

	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM} wbSelT;

	typedef struct packed {
		opcodeT aluOp;
		regIdxT rd;
		regIdxT rs;
		logic regWe;
		logic flagWe;
		wbSelT wbSel;
		logic memWe;
		pcSelT pcSel;
		wordT imm;
		logic halt;
	} ctrlT;

	typedef struct packed {
		logic irLoad;
		logic execEn;
		logic pcEn;
		logic halted;
	} phaseT;

endpackage

`default_nettype wire

//--- logic/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic en,
	input pcSelT sel,
	input wordT target,
	input wordT regValue,
	output wordT pc
);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (en) begin
			case (sel)
				// Absolute jump from the instruction
				PC_IMM: begin
					pc <= target;
				end
				PC_REG: begin
					pc <= regValue;
				end
				default: begin
					pc <= pc + 16'd1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input ctrlT ctrl,
	output phaseT phase,
	output cpuStateT state
);

	cpuStateT nextState;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = FETCH;
				end
			end
			FETCH: nextState = EXEC;
			EXEC: begin
				if (ctrl.halt) begin
					nextState = HALTED;
				end else if (ctrl.memWe) begin
					// Store needs the extra cycle
					nextState = WBACK;
				end else begin
					nextState = FETCH;
				end
			end
			WBACK: nextState = FETCH;
			HALTED: nextState = HALTED;
			default: nextState = IDLE;
		endcase
	end

	always_comb begin
		phase = '0;
		phase.irLoad = (state == FETCH);
		phase.execEn = (state == EXEC);
		phase.pcEn = ((state == EXEC) && !ctrl.memWe) || (state == WBACK);
		phase.halted = (state == HALTED);
	end

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
	input wordT instr,
	input wire logic cFlag,
	input wire logic zFlag,
	output ctrlT ctrl
);

	opcodeT opcode;

	assign opcode = opcodeT'(instr[15:12]);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = opcode;
		ctrl.rd = instr[11:8];
		ctrl.rs = instr[7:4];
		ctrl.imm = {8'h00, instr[7:0]};
		ctrl.wbSel = WB_ALU;
		ctrl.pcSel = PC_INCR;

		case (opcode)
			ADD, SUB, AND, OR, XOR, SHL: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			MOV: ctrl.regWe = 1'b1;
			LDI: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = WB_IMM;
			end
			LD: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = WB_MEM;
			end
			ST: ctrl.memWe = 1'b1;
			JMP: ctrl.pcSel = PC_IMM;
			// Conditional jumps fall through when the flag is clear
			JZ: ctrl.pcSel = zFlag ? PC_IMM : PC_INCR;
			JC: ctrl.pcSel = cFlag ? PC_IMM : PC_INCR;
			JR: ctrl.pcSel = PC_REG;
			HALT: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input regIdxT rd,
	input regIdxT rs,
	input wordT wData,
	output wordT rdData,
	output wordT rsData
);

	wordT regs [16];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= wData;
		end
	end

	// Reads see the old value until the edge
	assign rdData = regs[rd];
	assign rsData = regs[rs];

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic flagWe,
	input opcodeT op,
	input wordT a,
	input wordT b,
	output wordT result,
	output logic cFlag,
	output logic zFlag
);

	// Bit 16 carries the carry, borrow or shifted-out bit
	logic [16:0] wide;

	always_comb begin
		case (op)
			ADD: wide = {1'b0, a} + {1'b0, b};
			SUB: wide = {1'b0, a} - {1'b0, b};
			AND: wide = {1'b0, a & b};
			OR: wide = {1'b0, a | b};
			XOR: wide = {1'b0, a ^ b};
			MOV: wide = {1'b0, b};
			SHL: wide = {a, 1'b0};
			default: wide = '0;
		endcase
	end

	assign result = wide[15:0];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= wide[16];
			zFlag <= (wide[15:0] == 16'd0);
		end
	end

endmodule

`default_nettype wire

//--- logic/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wordT memRData,
	output wordT memAddr,
	output wordT memWData,
	output logic memWe,
	output logic halted,
	output logic idle
);

	wordT ir;
	wordT pc;
	wordT rdData;
	wordT rsData;
	wordT aluResult;
	wordT wbData;
	ctrlT ctrl;
	phaseT phase;
	cpuStateT state;
	logic cFlag;
	logic zFlag;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			ir <= '0;
		end else if (phase.irLoad) begin
			ir <= memRData;
		end
	end

	controlFsm fsm (
		.clk(clk), .rst(rst), .start(start), .ctrl(ctrl), .phase(phase), .state(state)
	);

	programCounter pcReg (
		.clk(clk), .rst(rst), .en(phase.pcEn), .sel(ctrl.pcSel),
		.target(ctrl.imm), .regValue(rsData), .pc(pc)
	);

	instrDecoder decoder (.instr(ir), .cFlag(cFlag), .zFlag(zFlag), .ctrl(ctrl));

	registerFile regFile (
		.clk(clk), .rst(rst), .we(ctrl.regWe & phase.execEn), .rd(ctrl.rd), .rs(ctrl.rs),
		.wData(wbData), .rdData(rdData), .rsData(rsData)
	);

	alu aluUnit (
		.clk(clk), .rst(rst), .flagWe(ctrl.flagWe & phase.execEn), .op(ctrl.aluOp),
		.a(rdData), .b(rsData), .result(aluResult), .cFlag(cFlag), .zFlag(zFlag)
	);

	always_comb begin
		case (ctrl.wbSel)
			WB_IMM: wbData = ctrl.imm;
			WB_MEM: wbData = memRData;
			default: wbData = aluResult;
		endcase
	end

	// LD addresses through rs, ST through rd
	assign memAddr = phase.irLoad ? pc : ((ctrl.wbSel == WB_MEM) ? rsData : rdData);
	assign memWData = rsData;
	assign memWe = ctrl.memWe & phase.execEn;
	assign halted = phase.halted;
	assign idle = (state == IDLE);

endmodule

`default_nettype wire

//--- logic/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic loadWe,
	input wordT loadAddr,
	input wordT loadData,
	output logic halted,
	output logic storeWe,
	output wordT storeAddr,
	output wordT storeData
);

	wordT mem [1 << memAddrW];
	wordT memAddr;
	wordT memWData;
	wordT memRData;
	logic memWe;
	logic idle;

	// Upper address bits are ignored
	assign memRData = mem[memAddr[memAddrW-1:0]];

	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[memAddr[memAddrW-1:0]] <= memWData;
		end else if (loadWe && (idle || halted)) begin
			mem[loadAddr[memAddrW-1:0]] <= loadData;
		end
	end

	cpuCore core (
		.clk(clk), .rst(rst), .start(start), .memRData(memRData), .memAddr(memAddr),
		.memWData(memWData), .memWe(memWe), .halted(halted), .idle(idle)
	);

	assign storeWe = memWe;
	assign storeAddr = memAddr;
	assign storeData = memWData;

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	input wire logic resetReq,
	output logic clk,
	output logic rst
);

	logic [3:0] holdCnt;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset holds for eight rising edges after power-up or a request
	initial holdCnt = 4'd8;

	always @(posedge clk) begin
		if (resetReq) begin
			holdCnt <= 4'd8;
		end else if (holdCnt != 4'd0) begin
			holdCnt <= holdCnt - 4'd1;
		end
	end

	assign rst = (holdCnt != 4'd0);

endmodule

`default_nettype wire

//--- verification/cpuCore_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_assertions import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input cpuStateT state,
	input wire logic memWe,
	input wire logic halted
);

	storeOnlyInExec: assert property (@(posedge clk) disable iff (rst) memWe |-> state == EXEC)
		else $error("memory write enable outside EXEC");

	legalState: assert property (@(posedge clk) disable iff (rst)
		state inside {IDLE, FETCH, EXEC, WBACK, HALTED})
		else $error("state register holds an illegal encoding");

	haltedOnlyInHalted: assert property (@(posedge clk) disable iff (rst)
		halted |-> state == HALTED)
		else $error("halted raised outside HALTED");

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	logic clk;
	logic rst;
	logic resetReq;
	logic start;
	logic loadWe;
	wordT loadAddr;
	wordT loadData;
	logic halted;
	logic storeWe;
	wordT storeAddr;
	wordT storeData;

	wordT image [256];
	int progLen;
	wordT expAddr [$];
	wordT expData [$];
	int storeCount;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic abortRun = 1'b0;
	logic [31:0] lfsrState = 32'h21b55fd2;

	clockGen clockGenInst (.resetReq(resetReq), .clk(clk), .rst(rst));

	cpuTop cpuTop_inst (
		.clk(clk), .rst(rst), .start(start), .loadWe(loadWe), .loadAddr(loadAddr),
		.loadData(loadData), .halted(halted), .storeWe(storeWe), .storeAddr(storeAddr),
		.storeData(storeData)
	);

	bind cpuCore cpuCore_assertions coreChecks (
		.clk(clk), .rst(rst), .state(state), .memWe(memWe), .halted(halted)
	);

	task automatic checkEqual(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned randBits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	function automatic wordT instr(input opcodeT op, input regIdxT rd, input logic [7:0] low);
		return {op, rd, low};
	endfunction

	function automatic wordT rr(input opcodeT op, input regIdxT rd, input regIdxT rs);
		return {op, rd, rs, 4'h0};
	endfunction

	// ISA model of the program image; fills the expected store queues
	function automatic int modelRun();
		wordT m [256];
		wordT r [16];
		wordT pc;
		wordT w;
		wordT a;
		wordT b;
		logic c;
		logic z;
		logic done;
		int steps;
		m = image;
		for (int i = 0; i < 16; i++) r[i] = '0;
		pc = '0;
		c = 1'b0;
		z = 1'b0;
		done = 1'b0;
		steps = 0;
		expAddr.delete();
		expData.delete();
		while (!done && steps < 1500) begin
			w = m[pc[7:0]];
			a = r[w[11:8]];
			b = r[w[7:4]];
			pc = pc + 16'd1;
			steps++;
			case (w[15:12])
				4'h1: begin
					r[w[11:8]] = a + b;
					c = (32'(a) + 32'(b)) > 32'hFFFF;
					z = (r[w[11:8]] == 16'd0);
				end
				4'h2: begin
					r[w[11:8]] = a - b;
					c = (a < b);
					z = (a == b);
				end
				4'h3, 4'h4, 4'h5: begin
					if (w[15:12] == 4'h3) r[w[11:8]] = a & b;
					else if (w[15:12] == 4'h4) r[w[11:8]] = a | b;
					else r[w[11:8]] = a ^ b;
					c = 1'b0;
					z = (r[w[11:8]] == 16'd0);
				end
				4'h6: r[w[11:8]] = b;
				4'h7: r[w[11:8]] = {8'h00, w[7:0]};
				4'h8: r[w[11:8]] = m[b[7:0]];
				4'h9: begin
					m[a[7:0]] = b;
					expAddr.push_back(a);
					expData.push_back(b);
				end
				4'hA: pc = {8'h00, w[7:0]};
				4'hB: if (z) pc = {8'h00, w[7:0]};
				4'hC: if (c) pc = {8'h00, w[7:0]};
				4'hD: pc = b;
				4'hE: begin
					c = a[15];
					r[w[11:8]] = a << 1;
					z = (r[w[11:8]] == 16'd0);
				end
				4'hF: done = 1'b1;
				default: ;
			endcase
		end
		return expAddr.size();
	endfunction

	// Stores are sampled mid-cycle on the falling edge
	always @(negedge clk) begin
		if (!rst && storeWe) begin
			storeCount++;
			if (expAddr.size() == 0) begin
				$display("Unexpected extra store to %h at %0t ns", storeAddr, $time);
				errorCount++;
			end else begin
				checkEqual(storeAddr, expAddr.pop_front(), "store address");
				checkEqual(storeData, expData.pop_front(), "store data");
			end
		end
	end

	task automatic newProgram();
		for (int a = 0; a < 256; a++) begin
			image[a] = {a[7:0] ^ 8'h5C, ~a[7:0]};
		end
		progLen = 0;
	endtask

	task automatic emit(input wordT w);
		image[progLen] = w;
		progLen++;
	endtask

	task automatic storeReg(input logic [7:0] addr, input regIdxT r);
		emit(instr(LDI, 4'd14, addr));
		emit(rr(ST, 4'd14, r));
	endtask

	task automatic runTest(input string name);
		int expCount;
		int cycles;
		int errorsBefore;
		if (!abortRun) begin
			errorsBefore = errorCount;
			expCount = modelRun();
			storeCount = 0;
			testsRun++;
			@(posedge clk);
			#1 resetReq = 1'b1;
			@(posedge clk);
			#1 resetReq = 1'b0;
			cycles = 0;
			while (rst && cycles < 20) begin
				@(posedge clk);
				#1 cycles++;
			end
			for (int a = 0; a < 256; a++) begin
				loadWe = 1'b1;
				loadAddr = wordT'(a);
				loadData = image[a];
				@(posedge clk);
				#1;
			end
			loadWe = 1'b0;
			start = 1'b1;
			@(posedge clk);
			#1 start = 1'b0;
			cycles = 0;
			while (!halted && cycles < 2000) begin
				@(posedge clk);
				#1 cycles++;
			end
			if (rst || !halted) begin
				$display("Test %s timed out: the core did not halt within 2000 cycles", name);
				errorCount++;
				abortRun = 1'b1;
			end else begin
				checkEqual(wordT'(storeCount), wordT'(expCount), "store count");
			end
			if (errorCount != errorsBefore) testsFailed++;
			$display("Test %s %s (%0d stores)", name,
				(errorCount == errorsBefore) ? "ok" : "failed", storeCount);
		end
	endtask

	function automatic opcodeT pickOp(input int unsigned k);
		case (k % 7)
			0: return ADD;
			1: return SUB;
			2: return AND;
			3: return OR;
			4: return XOR;
			5: return MOV;
			default: return SHL;
		endcase
	endfunction

	initial begin
		int j;
		int loopTop;
		regIdxT rd;
		resetReq = 1'b0;
		start = 1'b0;
		loadWe = 1'b0;
		loadAddr = '0;
		loadData = '0;

		newProgram();
		emit(instr(LDI, 4'd1, 8'h5A));
		emit(instr(LDI, 4'd2, 8'hC3));
		for (int i = 0; i < 5; i++) begin
			emit(rr(MOV, 4'd3, 4'd1));
			emit(rr(pickOp(i), 4'd3, 4'd2));
			storeReg(8'h80 + 8'(i), 4'd3);
		end
		emit(rr(MOV, 4'd3, 4'd2));
		storeReg(8'h85, 4'd3);
		emit(instr(LDI, 4'd1, 8'hFF));
		for (int i = 0; i < 9; i++) begin
			emit(rr(SHL, 4'd1, 4'd0));
			storeReg(8'h86 + 8'(i), 4'd1);
		end
		emit(instr(HALT, 4'd0, 8'h00));
		runTest("arith");

		newProgram();
		emit(instr(LDI, 4'd1, 8'h00));
		emit(instr(LDI, 4'd2, 8'h01));
		emit(instr(LDI, 4'd9, 8'hAA));
		emit(rr(SUB, 4'd1, 4'd2));
		j = progLen;
		emit(0);
		storeReg(8'h70, 4'd9);
		image[j] = instr(JC, 4'd0, 8'(progLen));
		storeReg(8'h71, 4'd1);
		emit(rr(ADD, 4'd1, 4'd2));
		j = progLen;
		emit(0);
		storeReg(8'h72, 4'd9);
		image[j] = instr(JZ, 4'd0, 8'(progLen));
		// Overflowing ADD leaves carry set
		j = progLen;
		emit(0);
		storeReg(8'h79, 4'd9);
		image[j] = instr(JC, 4'd0, 8'(progLen));
		storeReg(8'h73, 4'd1);
		emit(instr(LDI, 4'd3, 8'h05));
		emit(rr(ADD, 4'd3, 4'd2));
		j = progLen;
		emit(0);
		storeReg(8'h74, 4'd3);
		image[j] = instr(JC, 4'd0, 8'(progLen));
		j = progLen;
		emit(0);
		storeReg(8'h75, 4'd3);
		image[j] = instr(JZ, 4'd0, 8'(progLen));
		emit(rr(XOR, 4'd3, 4'd3));
		j = progLen;
		emit(0);
		storeReg(8'h76, 4'd9);
		image[j] = instr(JC, 4'd0, 8'(progLen));
		j = progLen;
		emit(0);
		storeReg(8'h77, 4'd9);
		image[j] = instr(JZ, 4'd0, 8'(progLen));
		storeReg(8'h78, 4'd2);
		emit(instr(HALT, 4'd0, 8'h00));
		runTest("flags");

		newProgram();
		emit(instr(LDI, 4'd9, 8'h3C));
		j = progLen;
		emit(0);
		storeReg(8'h60, 4'd9);
		image[j] = instr(JMP, 4'd0, 8'(progLen));
		storeReg(8'h61, 4'd9);
		j = progLen;
		emit(0);
		emit(rr(JR, 4'd0, 4'd5));
		storeReg(8'h62, 4'd9);
		image[j] = instr(LDI, 4'd5, 8'(progLen));
		storeReg(8'h63, 4'd5);
		emit(instr(LDI, 4'd1, 8'h00));
		emit(instr(LDI, 4'd2, 8'h01));
		emit(instr(LDI, 4'd3, 8'h04));
		emit(instr(LDI, 4'd7, 8'h90));
		loopTop = progLen;
		emit(rr(ADD, 4'd1, 4'd2));
		emit(rr(MOV, 4'd6, 4'd7));
		emit(rr(ADD, 4'd6, 4'd1));
		emit(rr(ST, 4'd6, 4'd1));
		emit(rr(MOV, 4'd4, 4'd3));
		emit(rr(SUB, 4'd4, 4'd1));
		j = progLen;
		emit(0);
		emit(instr(JMP, 4'd0, 8'(loopTop)));
		image[j] = instr(JZ, 4'd0, 8'(progLen));
		emit(instr(HALT, 4'd0, 8'h00));
		runTest("control");

		newProgram();
		emit(instr(LDI, 4'd1, 8'hA0));
		emit(rr(LD, 4'd2, 4'd1));
		emit(instr(LDI, 4'd3, 8'h07));
		emit(rr(ADD, 4'd2, 4'd3));
		emit(instr(LDI, 4'd4, 8'hB0));
		emit(rr(ST, 4'd4, 4'd2));
		emit(rr(LD, 4'd5, 4'd4));
		emit(rr(SHL, 4'd5, 4'd0));
		emit(instr(LDI, 4'd4, 8'hB1));
		emit(rr(ST, 4'd4, 4'd5));
		emit(instr(LDI, 4'd1, 8'hA1));
		emit(rr(LD, 4'd6, 4'd1));
		emit(rr(XOR, 4'd6, 4'd5));
		emit(instr(LDI, 4'd4, 8'hB2));
		emit(rr(ST, 4'd4, 4'd6));
		emit(instr(HALT, 4'd0, 8'h00));
		image[8'hA0] = 16'h1234;
		image[8'hA1] = 16'hF00F;
		runTest("memory");

		for (int p = 0; p < 4; p++) begin
			newProgram();
			for (int r = 1; r < 8; r++) begin
				emit(instr(LDI, regIdxT'(r), 8'(randBits(8))));
			end
			for (int i = 0; i < 12; i++) begin
				rd = regIdxT'(1 + randBits(3) % 7);
				emit(rr(pickOp(randBits(3)), rd, regIdxT'(1 + randBits(3) % 7)));
				storeReg(8'hC0 + 8'(i), rd);
			end
			emit(instr(HALT, 4'd0, 8'h00));
			runTest($sformatf("random%0d", p));
		end

		// Registers must come out of reset as zero
		newProgram();
		storeReg(8'hD0, 4'd1);
		storeReg(8'hD1, 4'd7);
		emit(instr(LDI, 4'd1, 8'h42));
		storeReg(8'hD2, 4'd1);
		emit(instr(HALT, 4'd0, 8'h00));
		runTest("restart");

		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
logic/cpuPkg.sv
logic/programCounter.sv
logic/controlFsm.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/alu.sv
logic/cpuCore.sv
logic/cpuTop.sv
verification/clockGen.sv
verification/cpuCore_assertions.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP ?= cpuTb
FILELIST ?= sim.f
LOG ?= sim.log
EXE = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(EXE) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
